//--- Bender.yml
package:
  name: bank_isu

sources:
  - common/bank_isu_pkg.sv
  - hdl/rob_id_gen.sv
  - bank_isu/bank_isu_iq.sv
  - bank_isu/bank_isu_inflight.sv
  - bank_isu/bank_isu_sched.sv
  - bank_isu/bank_isu_top.sv
  - target: simulation
    files:
      - verif/bank_isu_props.sv
      - verif/bank_isu_tb.sv

//--- bank_isu/bank_isu_inflight.sv
/* one bit per set and way for fills that have not returned yet
   set and clear take effect at the next edge, set wins on the same bit */
`timescale 1ns/1ps
`default_nettype none

module bank_isu_inflight (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           fill_valid_i,   // fill announce from htu
  input  logic [bank_isu_pkg::SET_W-1:0] fill_set_i,
  input  logic [bank_isu_pkg::WAY_W-1:0] fill_way_i,
  input  logic                           clr_valid_i,    // fill beat taken
  input  logic [bank_isu_pkg::RID_W-1:0] clr_rid_i,
  input  logic [bank_isu_pkg::SET_W-1:0] look_set_i,
  input  logic [bank_isu_pkg::WAY_W-1:0] look_way_i,
  output logic                           busy_o
);

  import bank_isu_pkg::*;

  localparam int ENT_N = SET_N * WAY_N;

  logic [ENT_N-1:0] flag_q;
  logic [ENT_N-1:0] set_mask;
  logic [ENT_N-1:0] clr_mask;
  logic [RID_W-1:0] fill_idx;
  logic [RID_W-1:0] look_idx;

  assign fill_idx = {fill_set_i, fill_way_i};
  assign look_idx = {look_set_i, look_way_i};

  // one-hot decode of both index words
  assign set_mask = ENT_N'(fill_valid_i) << fill_idx;
  assign clr_mask = ENT_N'(clr_valid_i) << clr_rid_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      flag_q <= '0;
    end else begin
      flag_q <= set_mask | (flag_q & ~clr_mask);
    end
  end

  assign busy_o = flag_q[look_idx];   // registered bit, no bypass

endmodule

`default_nettype wire

//--- bank_isu/bank_isu_iq.sv
/* in-order request queue of 2**PTR_WIDTH entries, head is combinational
   pop is only honoured while head_valid_o is high */
`timescale 1ns/1ps
`default_nettype none

module bank_isu_iq #(
  parameter int PTR_WIDTH = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  // request side
  input  logic                            req_valid_i,
  output logic                            req_allowin_o,
  input  logic [bank_isu_pkg::ROB_W-1:0]  req_rob_id_i,
  input  logic [bank_isu_pkg::CH_W-1:0]   req_ch_id_i,
  input  logic [bank_isu_pkg::OP_W-1:0]   req_opcode_i,
  input  logic [bank_isu_pkg::SWO_W-1:0]  req_set_way_offset_i,
  input  logic [bank_isu_pkg::WBUF_W-1:0] req_wbuffer_id_i,
  input  logic [bank_isu_pkg::ST_W-1:0]   req_off0_state_i,
  input  logic [bank_isu_pkg::ST_W-1:0]   req_off1_state_i,
  // head side
  output logic                            head_valid_o,
  output logic [bank_isu_pkg::ROB_W-1:0]  head_rob_id_o,
  output logic [bank_isu_pkg::CH_W-1:0]   head_ch_id_o,
  output logic [bank_isu_pkg::OP_W-1:0]   head_opcode_o,
  output logic [bank_isu_pkg::SWO_W-1:0]  head_set_way_offset_o,
  output logic [bank_isu_pkg::WBUF_W-1:0] head_wbuffer_id_o,
  output logic [bank_isu_pkg::ST_W-1:0]   head_off0_state_o,
  output logic [bank_isu_pkg::ST_W-1:0]   head_off1_state_o,
  input  logic                            head_pop_i
);

  import bank_isu_pkg::*;

  localparam int DEPTH = 1 << PTR_WIDTH;
  localparam int ENT_W = ROB_W + CH_W + OP_W + SWO_W + WBUF_W + 2 * ST_W;

  logic [ENT_W-1:0]   mem_q [DEPTH];
  logic [PTR_WIDTH:0] wr_ptr_q;   // msb is the wrap bit
  logic [PTR_WIDTH:0] rd_ptr_q;
  logic               full;
  logic               empty;
  logic               push;
  logic               pop;

  assign empty = wr_ptr_q == rd_ptr_q;
  assign full  = (wr_ptr_q[PTR_WIDTH] != rd_ptr_q[PTR_WIDTH]) &&
                 (wr_ptr_q[PTR_WIDTH-1:0] == rd_ptr_q[PTR_WIDTH-1:0]);

  assign req_allowin_o = !full;
  assign head_valid_o  = !empty;
  assign push          = req_valid_i && !full;
  assign pop           = head_pop_i && !empty;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q[PTR_WIDTH-1:0]] <= {req_rob_id_i, req_ch_id_i, req_opcode_i,
                                         req_set_way_offset_i, req_wbuffer_id_i,
                                         req_off0_state_i, req_off1_state_i};
    end
  end

  assign {head_rob_id_o, head_ch_id_o, head_opcode_o, head_set_way_offset_o,
          head_wbuffer_id_o, head_off0_state_o, head_off1_state_o} =
         mem_q[rd_ptr_q[PTR_WIDTH-1:0]];

endmodule

`default_nettype wire

//--- bank_isu/bank_isu_sched.sv
/* picks a returning fill first, else the queue head, into one output register
   a read head needs a non-zero credit level on its channel; channel 3 has none */
`timescale 1ns/1ps
`default_nettype none

module bank_isu_sched (
  input  logic                            clk_i,
  input  logic                            rst_i,
  // fill return from biu
  input  logic                            rvalid_i,
  output logic                            rready_o,
  input  logic [bank_isu_pkg::LINE_W-1:0] rdata_i,
  input  logic [bank_isu_pkg::RID_W-1:0]  rid_i,
  output logic                            clr_valid_o,
  // queue head
  input  logic                            head_valid_i,
  input  logic [bank_isu_pkg::ROB_W-1:0]  head_rob_id_i,
  input  logic [bank_isu_pkg::CH_W-1:0]   head_ch_id_i,
  input  logic [bank_isu_pkg::OP_W-1:0]   head_opcode_i,
  input  logic [bank_isu_pkg::SWO_W-1:0]  head_set_way_offset_i,
  input  logic [bank_isu_pkg::WBUF_W-1:0] head_wbuffer_id_i,
  input  logic [bank_isu_pkg::ST_W-1:0]   head_off0_state_i,
  input  logic [bank_isu_pkg::ST_W-1:0]   head_off1_state_i,
  input  logic                            head_busy_i,
  output logic                            head_pop_o,
  // xbar credit levels
  input  logic [bank_isu_pkg::CRD_W-1:0]  ch0_credit_i,
  input  logic [bank_isu_pkg::CRD_W-1:0]  ch1_credit_i,
  input  logic [bank_isu_pkg::CRD_W-1:0]  ch2_credit_i,
  // issue port to sc
  output logic                            isu_sc_valid_o,
  input  logic                            sc_ready_i,
  output logic [bank_isu_pkg::CH_W-1:0]   isu_sc_channel_id_o,
  output logic [bank_isu_pkg::SCOP_W-1:0] isu_sc_opcode_o,
  output logic [bank_isu_pkg::SWO_W-1:0]  isu_sc_set_way_offset_o,
  output logic [bank_isu_pkg::WBUF_W-1:0] isu_sc_wbuffer_id_o,
  output logic [bank_isu_pkg::ROB_W-1:0]  isu_sc_xbar_rob_num_o,
  output logic [bank_isu_pkg::ST_W-1:0]   isu_sc_cacheline_dirty_offset0_o,
  output logic [bank_isu_pkg::ST_W-1:0]   isu_sc_cacheline_dirty_offset1_o,
  output logic [bank_isu_pkg::HALF_W-1:0] isu_sc_linefill_data_offset0_o,
  output logic [bank_isu_pkg::HALF_W-1:0] isu_sc_linefill_data_offset1_o
);

  import bank_isu_pkg::*;

  fill_line_u        fill_w;
  logic [CRD_W-1:0]  head_credit;
  logic [SCOP_W-1:0] req_op;
  logic              slot_free;
  logic              fill_take;
  logic              head_ok;

  // -------------------------------------------------------------------------
  // selection
  // -------------------------------------------------------------------------
  assign slot_free   = !isu_sc_valid_o || sc_ready_i;   // empty or draining now
  assign rready_o    = slot_free;
  assign fill_take   = rvalid_i && slot_free;
  assign clr_valid_o = fill_take;

  always_comb begin
    case (head_ch_id_i)
      2'd0:    head_credit = ch0_credit_i;
      2'd1:    head_credit = ch1_credit_i;
      2'd2:    head_credit = ch2_credit_i;
      default: head_credit = '0;
    endcase
  end

  assign head_ok    = head_valid_i && !head_busy_i &&
                      (head_opcode_i != OP_RD || head_credit != '0);
  assign head_pop_o = slot_free && !rvalid_i && head_ok;   // fill goes first

  // reserved htu code leaves as a write
  assign req_op = (head_opcode_i == OP_RD || head_opcode_i == OP_EVICT) ?
                  {1'b0, head_opcode_i} : {1'b0, OP_WR};

  assign fill_w.line = rdata_i;

  // -------------------------------------------------------------------------
  // output register, held while valid and not ready
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      isu_sc_valid_o <= 1'b0;
    end else if (slot_free) begin
      isu_sc_valid_o <= fill_take || head_pop_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_take) begin
      isu_sc_channel_id_o              <= '0;
      isu_sc_opcode_o                  <= OP_LINEFILL;
      isu_sc_set_way_offset_o          <= {rid_i, 1'b0};   // offset 0
      isu_sc_wbuffer_id_o              <= '0;
      isu_sc_xbar_rob_num_o            <= '0;
      isu_sc_cacheline_dirty_offset0_o <= '0;
      isu_sc_cacheline_dirty_offset1_o <= '0;
      isu_sc_linefill_data_offset0_o   <= fill_w.halves.offset0;
      isu_sc_linefill_data_offset1_o   <= fill_w.halves.offset1;
    end else if (head_pop_o) begin
      isu_sc_channel_id_o              <= head_ch_id_i;
      isu_sc_opcode_o                  <= req_op;
      isu_sc_set_way_offset_o          <= head_set_way_offset_i;
      isu_sc_wbuffer_id_o              <= head_wbuffer_id_i;
      isu_sc_xbar_rob_num_o            <= head_rob_id_i;
      isu_sc_cacheline_dirty_offset0_o <= head_off0_state_i;
      isu_sc_cacheline_dirty_offset1_o <= head_off1_state_i;
      isu_sc_linefill_data_offset0_o   <= '0;
      isu_sc_linefill_data_offset1_o   <= '0;
    end
  end

endmodule

`default_nettype wire

//--- bank_isu/bank_isu_top.sv
/* bank issue unit: htu requests and biu fills in, one registered item out to sc
   credit counters live outside, only their levels come in */
`timescale 1ns/1ps
`default_nettype none

module bank_isu_top (
  input  logic                            clk_i,
  input  logic                            rst_i,
  // htu >> isu
  input  logic                            htu_isu_linefill_valid_i,
  input  logic [bank_isu_pkg::SET_W-1:0]  htu_isu_linefill_set_i,
  input  logic [bank_isu_pkg::WAY_W-1:0]  htu_isu_linefill_way_i,
  input  logic                            htu_isu_valid_i,
  output logic                            htu_isu_allowin_o,
  input  logic [bank_isu_pkg::CH_W-1:0]   htu_isu_ch_id_i,
  input  logic [bank_isu_pkg::OP_W-1:0]   htu_isu_opcode_i,
  input  logic [bank_isu_pkg::SWO_W-1:0]  htu_isu_set_way_offset_i,
  input  logic [bank_isu_pkg::WBUF_W-1:0] htu_isu_wbuffer_id_i,
  input  logic [bank_isu_pkg::ST_W-1:0]   htu_isu_cacheline_offset0_state_i,
  input  logic [bank_isu_pkg::ST_W-1:0]   htu_isu_cacheline_offset1_state_i,
  // biu >> isu
  input  logic                            biu_isu_rvalid_i,
  output logic                            biu_isu_rready_o,
  input  logic [bank_isu_pkg::LINE_W-1:0] biu_isu_rdata_i,
  input  logic [bank_isu_pkg::RID_W-1:0]  biu_isu_rid_i,
  // isu >> sc
  output logic                            isu_sc_valid_o,
  input  logic                            isu_sc_ready_i,
  output logic [bank_isu_pkg::CH_W-1:0]   isu_sc_channel_id_o,
  output logic [bank_isu_pkg::SCOP_W-1:0] isu_sc_opcode_o,
  output logic [bank_isu_pkg::SWO_W-1:0]  isu_sc_set_way_offset_o,
  output logic [bank_isu_pkg::WBUF_W-1:0] isu_sc_wbuffer_id_o,
  output logic [bank_isu_pkg::ROB_W-1:0]  isu_sc_xbar_rob_num_o,
  output logic [bank_isu_pkg::ST_W-1:0]   isu_sc_cacheline_dirty_offset0_o,
  output logic [bank_isu_pkg::ST_W-1:0]   isu_sc_cacheline_dirty_offset1_o,
  output logic [bank_isu_pkg::HALF_W-1:0] isu_sc_linefill_data_offset0_o,
  output logic [bank_isu_pkg::HALF_W-1:0] isu_sc_linefill_data_offset1_o,
  // xbar credit levels
  input  logic [bank_isu_pkg::CRD_W-1:0]  xbar_isu_ch0_credit_i,
  input  logic [bank_isu_pkg::CRD_W-1:0]  xbar_isu_ch1_credit_i,
  input  logic [bank_isu_pkg::CRD_W-1:0]  xbar_isu_ch2_credit_i
);

  import bank_isu_pkg::*;

  logic              kickoff;
  logic [ROB_W-1:0]  rob_id;
  logic              head_valid;
  logic [ROB_W-1:0]  head_rob_id;
  logic [CH_W-1:0]   head_ch_id;
  logic [OP_W-1:0]   head_opcode;
  logic [SWO_W-1:0]  head_swo;
  logic [WBUF_W-1:0] head_wbuf_id;
  logic [ST_W-1:0]   head_off0_st;
  logic [ST_W-1:0]   head_off1_st;
  logic              head_pop;
  logic              head_busy;
  logic              clr_valid;

  // -------------------------------------------------------------------------
  // request side
  // -------------------------------------------------------------------------
  assign kickoff = htu_isu_valid_i && htu_isu_allowin_o;   // accept strobe

  rob_id_gen #(
    .ID_WIDTH(ROB_W)
  ) u_rob_id_gen (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .ch_id_i  (htu_isu_ch_id_i),
    .kickoff_i(kickoff),
    .rob_id_o (rob_id)
  );

  bank_isu_iq #(
    .PTR_WIDTH(4)
  ) u_iq (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .req_valid_i          (htu_isu_valid_i),
    .req_allowin_o        (htu_isu_allowin_o),
    .req_rob_id_i         (rob_id),
    .req_ch_id_i          (htu_isu_ch_id_i),
    .req_opcode_i         (htu_isu_opcode_i),
    .req_set_way_offset_i (htu_isu_set_way_offset_i),
    .req_wbuffer_id_i     (htu_isu_wbuffer_id_i),
    .req_off0_state_i     (htu_isu_cacheline_offset0_state_i),
    .req_off1_state_i     (htu_isu_cacheline_offset1_state_i),
    .head_valid_o         (head_valid),
    .head_rob_id_o        (head_rob_id),
    .head_ch_id_o         (head_ch_id),
    .head_opcode_o        (head_opcode),
    .head_set_way_offset_o(head_swo),
    .head_wbuffer_id_o    (head_wbuf_id),
    .head_off0_state_o    (head_off0_st),
    .head_off1_state_o    (head_off1_st),
    .head_pop_i           (head_pop)
  );

  // head lookup uses the set and way bits above the offset bit
  bank_isu_inflight u_inflight (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fill_valid_i(htu_isu_linefill_valid_i),
    .fill_set_i  (htu_isu_linefill_set_i),
    .fill_way_i  (htu_isu_linefill_way_i),
    .clr_valid_i (clr_valid),
    .clr_rid_i   (biu_isu_rid_i),
    .look_set_i  (head_swo[SWO_W-1 -: SET_W]),
    .look_way_i  (head_swo[WAY_W:1]),
    .busy_o      (head_busy)
  );

  // -------------------------------------------------------------------------
  // issue side
  // -------------------------------------------------------------------------
  bank_isu_sched u_sched (
    .clk_i                           (clk_i),
    .rst_i                           (rst_i),
    .rvalid_i                        (biu_isu_rvalid_i),
    .rready_o                        (biu_isu_rready_o),
    .rdata_i                         (biu_isu_rdata_i),
    .rid_i                           (biu_isu_rid_i),
    .clr_valid_o                     (clr_valid),
    .head_valid_i                    (head_valid),
    .head_rob_id_i                   (head_rob_id),
    .head_ch_id_i                    (head_ch_id),
    .head_opcode_i                   (head_opcode),
    .head_set_way_offset_i           (head_swo),
    .head_wbuffer_id_i               (head_wbuf_id),
    .head_off0_state_i               (head_off0_st),
    .head_off1_state_i               (head_off1_st),
    .head_busy_i                     (head_busy),
    .head_pop_o                      (head_pop),
    .ch0_credit_i                    (xbar_isu_ch0_credit_i),
    .ch1_credit_i                    (xbar_isu_ch1_credit_i),
    .ch2_credit_i                    (xbar_isu_ch2_credit_i),
    .isu_sc_valid_o                  (isu_sc_valid_o),
    .sc_ready_i                      (isu_sc_ready_i),
    .isu_sc_channel_id_o             (isu_sc_channel_id_o),
    .isu_sc_opcode_o                 (isu_sc_opcode_o),
    .isu_sc_set_way_offset_o         (isu_sc_set_way_offset_o),
    .isu_sc_wbuffer_id_o             (isu_sc_wbuffer_id_o),
    .isu_sc_xbar_rob_num_o           (isu_sc_xbar_rob_num_o),
    .isu_sc_cacheline_dirty_offset0_o(isu_sc_cacheline_dirty_offset0_o),
    .isu_sc_cacheline_dirty_offset1_o(isu_sc_cacheline_dirty_offset1_o),
    .isu_sc_linefill_data_offset0_o  (isu_sc_linefill_data_offset0_o),
    .isu_sc_linefill_data_offset1_o  (isu_sc_linefill_data_offset1_o)
  );

endmodule

`default_nettype wire

//--- common/bank_isu_pkg.sv
/* geometry, opcodes and the fill word of the bank issue unit
   line is cut down to 64 bits as two 32-bit offsets; a biu rid is {set, way} */
`default_nettype none

package bank_isu_pkg;

  // -------------------------------------------------------------------------
  // line geometry
  // -------------------------------------------------------------------------
  localparam int SET_W  = 3;
  localparam int WAY_W  = 3;
  localparam int SET_N  = 1 << SET_W;
  localparam int WAY_N  = 1 << WAY_W;
  localparam int SWO_W  = 7;    // {set, way, offset}
  localparam int RID_W  = 6;    // {set, way}
  localparam int HALF_W = 32;
  localparam int LINE_W = 64;

  // request fields
  localparam int CH_N   = 3;
  localparam int CH_W   = 2;
  localparam int ROB_W  = 3;
  localparam int WBUF_W = 8;
  localparam int ST_W   = 2;    // state of one line offset
  localparam int CRD_W  = 3;    // xbar credit level

  // -------------------------------------------------------------------------
  // opcodes
  // -------------------------------------------------------------------------
  localparam int OP_W   = 2;
  localparam int SCOP_W = 3;

  // htu codes, code 3 is reserved and handled as a write
  localparam logic [OP_W-1:0]   OP_RD       = 2'd0;
  localparam logic [OP_W-1:0]   OP_WR       = 2'd1;
  localparam logic [OP_W-1:0]   OP_EVICT    = 2'd2;
  localparam logic [SCOP_W-1:0] OP_LINEFILL = 3'b100;   // sc only

  // returned line, either whole or as its two offsets
  typedef union packed {
    logic [LINE_W-1:0] line;
    struct packed {
      logic [HALF_W-1:0] offset1;
      logic [HALF_W-1:0] offset0;
    } halves;
  } fill_line_u;

endpackage

`default_nettype wire

//--- hdl/rob_id_gen.sv
/* one wrapping rob counter per channel, output follows ch_id_i combinationally
   channel ids at or above CH_N read as 0 and never advance */
`timescale 1ns/1ps
`default_nettype none

module rob_id_gen #(
  parameter int ID_WIDTH = 3
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic [bank_isu_pkg::CH_W-1:0] ch_id_i,
  input  logic                          kickoff_i,
  output logic [ID_WIDTH-1:0]           rob_id_o
);

  import bank_isu_pkg::*;

  logic [ID_WIDTH-1:0] cnt_q [CH_N];
  logic                ch_ok;

  assign ch_ok    = ch_id_i < CH_N;
  assign rob_id_o = ch_ok ? cnt_q[ch_id_i] : '0;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < CH_N; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (kickoff_i && ch_ok) begin
      cnt_q[ch_id_i] <= cnt_q[ch_id_i] + 1'b1;   // wraps at 2**ID_WIDTH
    end
  end

endmodule

`default_nettype wire

//--- project.f
common/bank_isu_pkg.sv
hdl/rob_id_gen.sv
bank_isu/bank_isu_iq.sv
bank_isu/bank_isu_inflight.sv
bank_isu/bank_isu_sched.sv
bank_isu/bank_isu_top.sv
verif/bank_isu_props.sv
verif/bank_isu_tb.sv

//--- verif/bank_isu_cases.txt
# kind a b c d e f g, all hex, missing columns read as 0
# 0 end test a | 1 request ch=a op=b swo=c wbuf=d st0=e st1=f, g copies (ch rotates, wbuf counts)
# 2 announce set=a way=b | 3 fill return rid=a data=b | 4 credit ch0=a ch1=b ch2=c
# 5 sc ready mode a (0 low, 1 high, 2 random) after allowin check b (0 none, 1 low, 2 high)
1 0 0 10 11 1 2 1
1 1 1 22 33 2 3 1
1 2 2 35 44 3 0 1
1 0 3 4a 55 1 1 1
0 1
5 2 0
1 0 1 60 80 0 0 18
1 1 0 62 a0 1 1 6
0 2
2 2 5
1 0 0 2b 01 0 0 1
1 1 1 30 02 1 0 1
1 2 1 31 03 0 1 1
3 15 0123456789abcdef
0 3
2 7 7
2 1 0
1 2 1 7e 10 2 2 1
3 08 fedcba9876543210
3 3f 55aa55aa00ff00ff
0 4
4 7 0 7
1 0 1 40 20 0 0 1
1 2 2 42 21 1 1 1
1 1 0 44 22 0 0 1
1 0 1 46 23 2 0 1
4 7 3 7
0 5
5 0 0
1 0 1 50 c0 1 2 11
5 1 1
0 6

//--- verif/bank_isu_props.sv
/* handshake rules of the sc issue port, bound into bank_isu_top
   credit is checked at the edge an item leaves */
`timescale 1ns/1ps
`default_nettype none

module bank_isu_props (
  input logic                            clk_i,
  input logic                            rst_i,
  input logic                            valid_i,
  input logic                            ready_i,
  input logic [bank_isu_pkg::CH_W-1:0]   ch_i,
  input logic [bank_isu_pkg::SCOP_W-1:0] opcode_i,
  input logic [90:0]                     fields_i,   // every sc field, data included
  input logic [bank_isu_pkg::CRD_W-1:0]  ch0_credit_i,
  input logic [bank_isu_pkg::CRD_W-1:0]  ch1_credit_i,
  input logic [bank_isu_pkg::CRD_W-1:0]  ch2_credit_i
);

  import bank_isu_pkg::*;

  logic [CRD_W-1:0] ch_credit;
  int               n_fail = 0;   // assertion failures so far

  always_comb begin
    case (ch_i)
      2'd0:    ch_credit = ch0_credit_i;
      2'd1:    ch_credit = ch1_credit_i;
      2'd2:    ch_credit = ch2_credit_i;
      default: ch_credit = '0;
    endcase
  end

  a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
                           valid_i && !ready_i |=> valid_i)
    else begin
      n_fail++;
      $error("issue valid dropped before ready");
    end

  a_stable: assert property (@(posedge clk_i) disable iff (rst_i)
                             valid_i && !ready_i |=> $stable(fields_i))
    else begin
      n_fail++;
      $error("issue fields changed while stalled");
    end

  a_credit: assert property (@(posedge clk_i) disable iff (rst_i)
                             valid_i && ready_i && opcode_i == {1'b0, OP_RD} |->
                             ch_credit != '0)
    else begin
      n_fail++;
      $error("read issued on a channel without credit");
    end

endmodule

bind bank_isu_top bank_isu_props u_props (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .valid_i     (isu_sc_valid_o),
  .ready_i     (isu_sc_ready_i),
  .ch_i        (isu_sc_channel_id_o),
  .opcode_i    (isu_sc_opcode_o),
  .fields_i    ({isu_sc_channel_id_o, isu_sc_opcode_o, isu_sc_set_way_offset_o,
                 isu_sc_wbuffer_id_o, isu_sc_xbar_rob_num_o,
                 isu_sc_cacheline_dirty_offset0_o, isu_sc_cacheline_dirty_offset1_o,
                 isu_sc_linefill_data_offset0_o, isu_sc_linefill_data_offset1_o}),
  .ch0_credit_i(xbar_isu_ch0_credit_i),
  .ch1_credit_i(xbar_isu_ch1_credit_i),
  .ch2_credit_i(xbar_isu_ch2_credit_i)
);

`default_nettype wire

//--- verif/bank_isu_tb.sv
/* runs verif/bank_isu_cases.txt (path from the project root) against bank_isu_top
   a fill or credit or announce record waits until every expected item has issued */
`timescale 1ns/1ps
`default_nettype none

module bank_isu_tb;

  import bank_isu_pkg::*;

  localparam int ITEM_W = CH_W + SCOP_W + SWO_W + WBUF_W + ROB_W + 2 * ST_W + 2 * HALF_W;

  logic              clk_i;
  logic              rst_i;
  logic              htu_isu_linefill_valid_i;
  logic [SET_W-1:0]  htu_isu_linefill_set_i;
  logic [WAY_W-1:0]  htu_isu_linefill_way_i;
  logic              htu_isu_valid_i;
  logic              htu_isu_allowin_o;
  logic [CH_W-1:0]   htu_isu_ch_id_i;
  logic [OP_W-1:0]   htu_isu_opcode_i;
  logic [SWO_W-1:0]  htu_isu_set_way_offset_i;
  logic [WBUF_W-1:0] htu_isu_wbuffer_id_i;
  logic [ST_W-1:0]   htu_isu_cacheline_offset0_state_i;
  logic [ST_W-1:0]   htu_isu_cacheline_offset1_state_i;
  logic              biu_isu_rvalid_i;
  logic              biu_isu_rready_o;
  logic [LINE_W-1:0] biu_isu_rdata_i;
  logic [RID_W-1:0]  biu_isu_rid_i;
  logic              isu_sc_valid_o;
  logic              isu_sc_ready_i;
  logic [CH_W-1:0]   isu_sc_channel_id_o;
  logic [SCOP_W-1:0] isu_sc_opcode_o;
  logic [SWO_W-1:0]  isu_sc_set_way_offset_o;
  logic [WBUF_W-1:0] isu_sc_wbuffer_id_o;
  logic [ROB_W-1:0]  isu_sc_xbar_rob_num_o;
  logic [ST_W-1:0]   isu_sc_cacheline_dirty_offset0_o;
  logic [ST_W-1:0]   isu_sc_cacheline_dirty_offset1_o;
  logic [HALF_W-1:0] isu_sc_linefill_data_offset0_o;
  logic [HALF_W-1:0] isu_sc_linefill_data_offset1_o;
  logic [CRD_W-1:0]  xbar_isu_ch0_credit_i;
  logic [CRD_W-1:0]  xbar_isu_ch1_credit_i;
  logic [CRD_W-1:0]  xbar_isu_ch2_credit_i;

  logic [ITEM_W-1:0]  sc_item;
  logic [7:0][63:0]   recs [$];    // kind in [0], columns a..g above it
  logic [ITEM_W-1:0]  exp_q [$];   // items the DUT must issue next, in order
  logic [ITEM_W-1:0]  miq [$];     // model queue, head still blocked
  logic [SET_N*WAY_N-1:0] mflag;   // model in-flight bits by {set, way}
  int                 credit [4];  // channel 3 never has credit
  int                 rob_cnt [4];
  int                 ready_mode;
  int                 seed;
  int                 n_checks;
  int                 n_errors;
  int                 n_items;
  int                 n_tests;
  int                 item_mark;
  int                 err_mark;
  logic               loaded = 1'b0;

  bank_isu_top bank_isu_top_i (.*);

  assign sc_item = {isu_sc_channel_id_o, isu_sc_opcode_o, isu_sc_set_way_offset_o,
                    isu_sc_wbuffer_id_o, isu_sc_xbar_rob_num_o,
                    isu_sc_cacheline_dirty_offset0_o, isu_sc_cacheline_dirty_offset1_o,
                    isu_sc_linefill_data_offset0_o, isu_sc_linefill_data_offset1_o};

  always #5 clk_i = ~clk_i;

  task automatic compare(input string what, input logic [ITEM_W-1:0] got,
                         input logic [ITEM_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ---------------------------------------------------------------------------
  // sc side: ready pattern and issue monitor
  // ---------------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (!rst_i) begin
      // rready high while the output register is empty or leaving
      compare("rready", ITEM_W'(biu_isu_rready_o),
              ITEM_W'(!isu_sc_valid_o || isu_sc_ready_i));
      case (ready_mode)
        0:       isu_sc_ready_i = 1'b0;
        1:       isu_sc_ready_i = 1'b1;
        default: isu_sc_ready_i = ($random(seed) & 3) != 0;   // stall one in four
      endcase
      if (isu_sc_valid_o && isu_sc_ready_i) begin   // leaves at the next edge
        n_items++;
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("unexpected item %h issued at %0t ns with nothing expected",
                   sc_item, $time);
        end else begin
          compare("issue item", sc_item, exp_q.pop_front());
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // reference model
  // ---------------------------------------------------------------------------
  task automatic advance();
    logic [CH_W-1:0]   ch;
    logic [SCOP_W-1:0] op;
    logic [SWO_W-1:0]  swo;
    while (miq.size() != 0) begin
      {ch, op, swo} = miq[0][ITEM_W-1 -: CH_W + SCOP_W + SWO_W];
      if (mflag[swo[SWO_W-1:1]]) break;                       // line still in flight
      if (op == {1'b0, OP_RD} && credit[ch] == 0) break;
      exp_q.push_back(miq.pop_front());
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
      #1;
    end
  endtask

  task automatic send_req(input logic [CH_W-1:0] ch, input logic [OP_W-1:0] op,
                          input logic [SWO_W-1:0] swo, input logic [WBUF_W-1:0] wbuf,
                          input logic [ST_W-1:0] st0, input logic [ST_W-1:0] st1);
    logic [SCOP_W-1:0] scop;
    @(negedge clk_i);
    htu_isu_valid_i                   = 1'b1;
    htu_isu_ch_id_i                   = ch;
    htu_isu_opcode_i                  = op;
    htu_isu_set_way_offset_i          = swo;
    htu_isu_wbuffer_id_i              = wbuf;
    htu_isu_cacheline_offset0_state_i = st0;
    htu_isu_cacheline_offset1_state_i = st1;
    #1;
    while (!htu_isu_allowin_o) begin
      @(negedge clk_i);
      #1;
    end
    // reserved code goes out as a write
    if (op == OP_RD || op == OP_EVICT) scop = {1'b0, op};
    else scop = {1'b0, OP_WR};
    miq.push_back({ch, scop, swo, wbuf, ROB_W'(rob_cnt[ch]), st0, st1, 64'd0});
    rob_cnt[ch] = (rob_cnt[ch] + 1) % (1 << ROB_W);
    advance();
  endtask

  task automatic announce(input logic [SET_W-1:0] set, input logic [WAY_W-1:0] way);
    wait_drain();
    @(negedge clk_i);
    htu_isu_linefill_valid_i = 1'b1;
    htu_isu_linefill_set_i   = set;
    htu_isu_linefill_way_i   = way;
    #1;
    mflag[{set, way}] = 1'b1;
    @(negedge clk_i);
    htu_isu_linefill_valid_i = 1'b0;
  endtask

  task automatic return_fill(input logic [RID_W-1:0] rid, input logic [LINE_W-1:0] data);
    wait_drain();
    @(negedge clk_i);
    biu_isu_rvalid_i = 1'b1;
    biu_isu_rid_i    = rid;
    biu_isu_rdata_i  = data;
    #1;
    while (!biu_isu_rready_o) begin
      @(negedge clk_i);
      #1;
    end
    exp_q.push_back({CH_W'(0), OP_LINEFILL, rid, 1'b0, WBUF_W'(0), ROB_W'(0),
                     ST_W'(0), ST_W'(0), data[HALF_W-1:0], data[LINE_W-1:HALF_W]});
    mflag[rid] = 1'b0;
    advance();   // a waiting head follows its fill
    @(negedge clk_i);
    biu_isu_rvalid_i = 1'b0;
  endtask

  task automatic set_credit(input int c0, input int c1, input int c2);
    wait_drain();
    @(negedge clk_i);
    xbar_isu_ch0_credit_i = CRD_W'(c0);
    xbar_isu_ch1_credit_i = CRD_W'(c1);
    xbar_isu_ch2_credit_i = CRD_W'(c2);
    #1;
    credit[0] = c0;
    credit[1] = c1;
    credit[2] = c2;
    advance();
  endtask

  task automatic set_ready(input int mode, input int allow_chk);
    @(negedge clk_i);
    #1;
    if (allow_chk != 0) compare("allowin", ITEM_W'(htu_isu_allowin_o), ITEM_W'(allow_chk == 2));
    ready_mode = mode;
  endtask

  task automatic end_test(input int num);
    wait_drain();
    repeat (4) @(negedge clk_i);   // room for a stray item to show
    if (miq.size() != 0) begin
      n_errors++;
      $display("test %0d ended with %0d requests that never became eligible", num, miq.size());
    end
    n_tests++;
    $display("test %0d finished: %0d items, %0d errors", num, n_items - item_mark,
             n_errors - err_mark);
    item_mark = n_items;
    err_mark  = n_errors;
  endtask

  task automatic run_record(input logic [7:0][63:0] r);
    int cnt;
    int i;
    case (r[0])
      0: end_test(int'(r[1]));
      1: begin
        cnt = (r[7] == 0) ? 1 : int'(r[7]);
        for (i = 0; i < cnt; i++) begin   // copies rotate channel, count up wbuffer id
          send_req(CH_W'((r[1] + i) % 3), OP_W'(r[2]), SWO_W'(r[3]), WBUF_W'(r[4] + i),
                   ST_W'(r[5]), ST_W'(r[6]));
        end
        @(negedge clk_i);
        htu_isu_valid_i = 1'b0;
      end
      2: announce(SET_W'(r[1]), WAY_W'(r[2]));
      3: return_fill(RID_W'(r[1]), r[2]);
      4: set_credit(int'(r[1]), int'(r[2]), int'(r[3]));
      5: set_ready(int'(r[1]), int'(r[2]));
      default: begin
        n_errors++;
        $display("case file holds unknown record kind %0d", r[0]);
      end
    endcase
  endtask

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------
  initial begin
    int          fd;
    int          rc;
    string       line;
    logic [63:0] k, a, b, c, d, e, f, g;
    clk_i = 1'b0;
    rst_i = 1'b1;
    htu_isu_linefill_valid_i          = 1'b0;
    htu_isu_linefill_set_i            = '0;
    htu_isu_linefill_way_i            = '0;
    htu_isu_valid_i                   = 1'b0;
    htu_isu_ch_id_i                   = '0;
    htu_isu_opcode_i                  = '0;
    htu_isu_set_way_offset_i          = '0;
    htu_isu_wbuffer_id_i              = '0;
    htu_isu_cacheline_offset0_state_i = '0;
    htu_isu_cacheline_offset1_state_i = '0;
    biu_isu_rvalid_i                  = 1'b0;
    biu_isu_rdata_i                   = '0;
    biu_isu_rid_i                     = '0;
    isu_sc_ready_i                    = 1'b1;
    xbar_isu_ch0_credit_i             = 3'd7;
    xbar_isu_ch1_credit_i             = 3'd7;
    xbar_isu_ch2_credit_i             = 3'd7;
    credit     = '{7, 7, 7, 0};
    rob_cnt    = '{0, 0, 0, 0};
    mflag      = '0;
    ready_mode = 1;
    seed       = 32'h5e17;
    n_checks   = 0;
    n_errors   = 0;
    n_items    = 0;
    n_tests    = 0;
    item_mark  = 0;
    err_mark   = 0;
    fd = $fopen("verif/bank_isu_cases.txt", "r");
    if (fd == 0) begin
      n_errors++;
      $display("could not open verif/bank_isu_cases.txt for reading");
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        if (rc > 0 && line.len() > 0 && line[0] != "#") begin
          {k, a, b, c, d, e, f, g} = '0;   // short records leave columns at zero
          rc = $sscanf(line, "%h %h %h %h %h %h %h %h", k, a, b, c, d, e, f, g);
          if (rc > 0) recs.push_back({g, f, e, d, c, b, a, k});
        end
      end
      $fclose(fd);
      loaded = 1'b1;
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    foreach (recs[i]) run_record(recs[i]);
    n_errors += bank_isu_top_i.u_props.n_fail;
    $display("%0d tests, %0d items, %0d checks, %0d errors", n_tests, n_items, n_checks,
             n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog, 200 cycles per record
  initial begin
    wait (loaded);
    repeat (recs.size() * 200) @(posedge clk_i);
    $display("timeout after %0d cycles, the DUT stopped making progress", recs.size() * 200);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
